// ==== files.f ====
+incdir+verilog
verilog/noc_pkg.sv
verilog/auto_init.sv
verilog/routing_fsm.sv
verilog/ingress_handler.sv
verilog/link_arbiter.sv
verilog/noc_node_init_top.sv
dv/tb_noc_node_init.sv

// ==== dv/tb_noc_node_init.sv ====
`timescale 1ns/1ns
`include "noc_settings.svh"

module tb_noc_node_init;
    localparam int init_attempts = 4;
    localparam int wd_cycles = (`NOC_PACK_TIME_OUT + `NOC_JACK_TIME_OUT) * init_attempts + 1000;

    logic                    nocclk = 1'b0;
    logic                    rst_n;
    logic [`NOC_ID_W-1:0]    node_id;
    logic [`NOC_ID_W-1:0]    other_id;
    logic                    in_valid;
    noc_pkg::flit_t          in_flit;
    logic                    inject_valid;
    noc_pkg::flit_t          inject_flit;
    logic                    inject_busy;
    logic                    link_valid;
    noc_pkg::flit_t          link_flit;
    logic                    deliver_valid;
    noc_pkg::flit_t          deliver_flit;
    noc_pkg::routing_state_t routing_state;

    noc_pkg::flit_t link_q[$];
    int             link_cyc[$];
    noc_pkg::flit_t deliver_q[$];
    int             deliver_cyc[$];
    int             cycle = 0;
    int             reset_cyc;
    int             busy_errs = 0;
    int             test_errs;
    int             pass_cnt = 0;
    int             fail_cnt = 0;
    logic [31:0]    lfsr_state = 32'h2eff_61db;

    noc_node_init_top i_dut (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .node_id      (node_id),
        .in_valid     (in_valid),
        .in_flit      (in_flit),
        .inject_valid (inject_valid),
        .inject_flit  (inject_flit),
        .inject_busy  (inject_busy),
        .link_valid   (link_valid),
        .link_flit    (link_flit),
        .deliver_valid(deliver_valid),
        .deliver_flit (deliver_flit),
        .routing_state(routing_state)
    );

    always #5 nocclk = ~nocclk;

    always @(posedge nocclk) cycle <= cycle + 1;

    // Outputs are collected mid-cycle, well away from both edges
    always @(negedge nocclk) begin
        if (link_valid) begin
            link_q.push_back(link_flit);
            link_cyc.push_back(cycle);
        end
        if (deliver_valid) begin
            deliver_q.push_back(deliver_flit);
            deliver_cyc.push_back(cycle);
        end
        if ((routing_state != noc_pkg::ROUTING) && !inject_busy)
            busy_errs++;
    end

    initial begin
        #(wd_cycles * 10);
        $display("Watchdog expired after %0d cycles, a test is stuck", wd_cycles);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step for every bit taken
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic noc_pkg::flit_t make_flit(input noc_pkg::flit_type_t t,
            input noc_pkg::sys_op_t op, input logic [`NOC_ID_W-1:0] src,
            input logic [`NOC_ID_W-1:0] dst, input logic [`NOC_PAYLOAD_W-1:0] payload);
        return {t, op, src, dst, payload};
    endfunction

    function automatic noc_pkg::flit_t sys_flit(input noc_pkg::sys_op_t op,
            input logic [`NOC_ID_W-1:0] src, input logic [`NOC_ID_W-1:0] dst);
        return make_flit(noc_pkg::SYSTEM, op, src, dst, '0);
    endfunction

    task automatic next_cycle();
        @(posedge nocclk);
        #1;
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", test, exp, act);
        test_errs++;
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        test_errs++;
    endtask

    task automatic finish_test(input string test);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("%s: passed", test);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", test, test_errs);
        end
    endtask

    task automatic send_flit(input noc_pkg::flit_t f);
        in_valid = 1'b1;
        in_flit  = f;
        next_cycle();
        in_valid = 1'b0;
    endtask

    // Returns cyc = -1 when nothing shows up within the limit
    task automatic wait_link(input int limit, output noc_pkg::flit_t f, output int cyc);
        int n;
        n   = 0;
        cyc = -1;
        f   = '0;
        while ((link_q.size() == 0) && (n < limit)) begin
            next_cycle();
            n++;
        end
        if (link_q.size() > 0) begin
            f   = link_q.pop_front();
            cyc = link_cyc.pop_front();
        end
    endtask

    // Payload of SYSTEM flits carries nothing, so only the header is compared
    task automatic expect_sys(input string test, input noc_pkg::flit_t exp, input int limit,
                              output int cyc);
        noc_pkg::flit_t f;
        wait_link(limit, f, cyc);
        if (cyc < 0)
            report_error({test, ": expected SYSTEM flit never appeared on the link"});
        else if ((f >> `NOC_PAYLOAD_W) !== (exp >> `NOC_PAYLOAD_W))
            report_mismatch(test, exp >> `NOC_PAYLOAD_W, f >> `NOC_PAYLOAD_W);
    endtask

    task automatic reset_parent_request();
        string          t = "reset_parent_request";
        noc_pkg::flit_t req;
        int             c0;
        int             c1;
        test_errs = 0;
        req = sys_flit(noc_pkg::S_PARENT_REQUEST, node_id, `NOC_BROADCAST_ID);
        expect_sys(t, req, 10, c0);
        if (c0 != reset_cyc + 2)  // INIT, GENERATE, then one cycle through the arbiter
            report_mismatch(t, reset_cyc + 2, c0);
        expect_sys(t, req, `NOC_PACK_TIME_OUT + 10, c1);
        // Wait runs through the cycle where the counter hits the limit
        if (c1 - c0 != `NOC_PACK_TIME_OUT + 3)
            report_mismatch(t, `NOC_PACK_TIME_OUT + 3, c1 - c0);
        finish_test(t);
    endtask

    task automatic join_timeout();
        string t = "join_timeout";
        int    c0;
        int    c1;
        test_errs = 0;
        send_flit(sys_flit(noc_pkg::S_PARENT_ACK, other_id, node_id));
        expect_sys(t, sys_flit(noc_pkg::S_JOIN_REQUEST, node_id, `NOC_BROADCAST_ID), 10, c0);
        expect_sys(t, sys_flit(noc_pkg::S_PARENT_REQUEST, node_id, `NOC_BROADCAST_ID),
                   `NOC_JACK_TIME_OUT + 10, c1);
        if (c1 - c0 != `NOC_JACK_TIME_OUT + 3)
            report_mismatch(t, `NOC_JACK_TIME_OUT + 3, c1 - c0);
        finish_test(t);
    endtask

    task automatic join_sequence();
        string t = "join_sequence";
        int    c0;
        test_errs = 0;
        send_flit(sys_flit(noc_pkg::S_PARENT_ACK, other_id, other_id));
        if (routing_state !== noc_pkg::I_WAIT_PARENT_ACK)
            report_mismatch(t, noc_pkg::I_WAIT_PARENT_ACK, routing_state);
        send_flit(sys_flit(noc_pkg::S_PARENT_ACK, other_id, node_id));
        expect_sys(t, sys_flit(noc_pkg::S_JOIN_REQUEST, node_id, `NOC_BROADCAST_ID), 10, c0);
        send_flit(sys_flit(noc_pkg::S_JOIN_ACK, other_id, other_id));
        if (routing_state !== noc_pkg::I_WAIT_JOIN_ACK)
            report_mismatch(t, noc_pkg::I_WAIT_JOIN_ACK, routing_state);
        send_flit(sys_flit(noc_pkg::S_JOIN_ACK, other_id, node_id));
        if (routing_state !== noc_pkg::ROUTING)
            report_mismatch(t, noc_pkg::ROUTING, routing_state);
        finish_test(t);
    endtask

    task automatic request_answers();
        string                t = "request_answers";
        logic [`NOC_ID_W-1:0] src;
        noc_pkg::sys_op_t     op;
        noc_pkg::sys_op_t     ack;
        int                   sent;
        int                   c;
        test_errs = 0;
        for (int i = 0; i < 6; i++) begin
            src  = `NOC_ID_W'(rand_bits(`NOC_ID_W));
            op   = (i % 2 == 0) ? noc_pkg::S_PARENT_REQUEST : noc_pkg::S_JOIN_REQUEST;
            ack  = (op == noc_pkg::S_JOIN_REQUEST) ? noc_pkg::S_JOIN_ACK : noc_pkg::S_PARENT_ACK;
            sent = cycle;
            send_flit(sys_flit(op, src, `NOC_BROADCAST_ID));
            expect_sys(t, sys_flit(ack, node_id, src), 10, c);
            if (c != sent + 2)
                report_mismatch(t, sent + 2, c);
            repeat (3) next_cycle();
            if (link_q.size() != 0) begin
                report_error("request_answers: more than one acknowledge for a request");
                link_q.delete();
                link_cyc.delete();
            end
        end
        finish_test(t);
    endtask

    task automatic local_injection();
        string          t = "local_injection";
        noc_pkg::flit_t f;
        noc_pkg::flit_t exp_q[$];
        int             n;
        int             n_req;
        int             n_ack;
        test_errs = 0;
        n_req = 0;
        n_ack = 0;
        if (busy_errs != 0)
            report_error("local_injection: inject_busy went low before ROUTING");
        for (int i = 0; i < 10; i++) begin
            f = make_flit(noc_pkg::DATA, noc_pkg::sys_op_t'(rand_bits(2)),
                          `NOC_ID_W'(rand_bits(`NOC_ID_W)), `NOC_ID_W'(rand_bits(`NOC_ID_W)),
                          `NOC_PAYLOAD_W'(rand_bits(`NOC_PAYLOAD_W)));
            n = 0;
            while (inject_busy && (n < 10)) begin
                next_cycle();
                n++;
            end
            if (inject_busy)
                report_error("local_injection: inject_busy stuck high");
            inject_valid = 1'b1;
            inject_flit  = f;
            exp_q.push_back(f);
            if (i % 2 == 0) begin  // A neighbor request in the same cycle
                in_valid = 1'b1;
                in_flit  = sys_flit(noc_pkg::S_PARENT_REQUEST, other_id, `NOC_BROADCAST_ID);
                n_req++;
            end
            next_cycle();
            inject_valid = 1'b0;
            in_valid     = 1'b0;
        end
        repeat (8) next_cycle();
        while (link_q.size() > 0) begin
            f = link_q.pop_front();
            void'(link_cyc.pop_front());
            if (f.flit_type == noc_pkg::SYSTEM)
                n_ack++;
            else if (exp_q.size() == 0)
                report_error("local_injection: extra DATA flit on the link");
            else if (f !== exp_q[0])
                report_mismatch(t, exp_q.pop_front(), f);
            else
                void'(exp_q.pop_front());
        end
        if (exp_q.size() != 0)
            report_error("local_injection: local flits missing from the link");
        if (n_ack != n_req)
            report_mismatch(t, n_req, n_ack);
        finish_test(t);
    endtask

    task automatic local_delivery();
        string          t = "local_delivery";
        noc_pkg::flit_t f;
        noc_pkg::flit_t exp_q[$];
        int             exp_cyc[$];
        test_errs = 0;
        if (deliver_q.size() != 0)
            report_error("local_delivery: flit delivered before any DATA flit for this node");
        deliver_q.delete();
        deliver_cyc.delete();
        for (int i = 0; i < 9; i++) begin
            f = make_flit(noc_pkg::DATA, noc_pkg::sys_op_t'(rand_bits(2)),
                          `NOC_ID_W'(rand_bits(`NOC_ID_W)), node_id,
                          `NOC_PAYLOAD_W'(rand_bits(`NOC_PAYLOAD_W)));
            if (i % 3 == 1)
                f.dst_id = other_id;
            if (i % 3 == 2) begin
                f.flit_type = noc_pkg::SYSTEM;
                f.sys_op    = noc_pkg::S_JOIN_ACK;  // Draws no answer while routing
            end
            if (i % 3 == 0) begin
                exp_q.push_back(f);
                exp_cyc.push_back(cycle + 1);
            end
            send_flit(f);
        end
        repeat (3) next_cycle();
        if (deliver_q.size() != exp_q.size())
            report_mismatch(t, exp_q.size(), deliver_q.size());
        while ((deliver_q.size() > 0) && (exp_q.size() > 0)) begin
            f = deliver_q.pop_front();
            if (f !== exp_q[0])
                report_mismatch(t, exp_q[0], f);
            if (deliver_cyc[0] != exp_cyc[0])
                report_mismatch(t, exp_cyc[0], deliver_cyc[0]);
            void'(exp_q.pop_front());
            void'(exp_cyc.pop_front());
            void'(deliver_cyc.pop_front());
        end
        finish_test(t);
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_flit      = '0;
        inject_valid = 1'b0;
        inject_flit  = '0;
        node_id      = `NOC_ID_W'(rand_bits(`NOC_ID_W));
        if (node_id == `NOC_BROADCAST_ID)
            node_id[0] = 1'b0;
        other_id = node_id ^ `NOC_ID_W'(rand_bits(`NOC_ID_W) | 32'd1);
        repeat (16) @(posedge nocclk);
        #1;
        rst_n     = 1'b1;
        reset_cyc = cycle;
        reset_parent_request();
        join_timeout();
        join_sequence();
        request_answers();
        local_injection();
        local_delivery();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog/noc_node_init_top.sv ====
`timescale 1ns/1ns
`include "noc_settings.svh"

module noc_node_init_top (
    input  logic                    nocclk,
    input  logic                    rst_n,
    input  logic [`NOC_ID_W-1:0]    node_id,
    input  logic                    in_valid,
    input  noc_pkg::flit_t          in_flit,
    input  logic                    inject_valid,
    input  noc_pkg::flit_t          inject_flit,
    output logic                    inject_busy,
    output logic                    link_valid,
    output noc_pkg::flit_t          link_flit,
    output logic                    deliver_valid,
    output noc_pkg::flit_t          deliver_flit,
    output noc_pkg::routing_state_t routing_state
);
    logic           is_next_state;
    logic           is_reset_state;
    logic           init_valid;
    noc_pkg::flit_t init_flit;
    logic           ack_valid;
    noc_pkg::flit_t ack_flit;

    routing_fsm i_routing_fsm (
        .nocclk        (nocclk),
        .rst_n         (rst_n),
        .is_next_state (is_next_state),
        .is_reset_state(is_reset_state),
        .routing_state (routing_state)
    );

    auto_init i_auto_init (
        .nocclk        (nocclk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_flit       (in_flit),
        .routing_state (routing_state),
        .node_id       (node_id),
        .is_next_state (is_next_state),
        .is_reset_state(is_reset_state),
        .init_valid    (init_valid),
        .init_flit     (init_flit)
    );

    ingress_handler i_ingress_handler (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_flit      (in_flit),
        .node_id      (node_id),
        .routing_state(routing_state),
        .ack_valid    (ack_valid),
        .ack_flit     (ack_flit),
        .deliver_valid(deliver_valid),
        .deliver_flit (deliver_flit)
    );

    // Single outgoing link shared by init, acks and local traffic
    link_arbiter i_link_arbiter (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .init_valid   (init_valid),
        .init_flit    (init_flit),
        .ack_valid    (ack_valid),
        .ack_flit     (ack_flit),
        .inject_valid (inject_valid),
        .inject_flit  (inject_flit),
        .routing_state(routing_state),
        .inject_busy  (inject_busy),
        .link_valid   (link_valid),
        .link_flit    (link_flit)
    );

endmodule

// ==== verilog/link_arbiter.sv ====
`timescale 1ns/1ns

module link_arbiter (
    input  logic                    nocclk,
    input  logic                    rst_n,
    input  logic                    init_valid,
    input  noc_pkg::flit_t          init_flit,
    input  logic                    ack_valid,
    input  noc_pkg::flit_t          ack_flit,
    input  logic                    inject_valid,
    input  noc_pkg::flit_t          inject_flit,
    input  noc_pkg::routing_state_t routing_state,
    output logic                    inject_busy,
    output logic                    link_valid,
    output noc_pkg::flit_t          link_flit
);
    localparam int n_req = 3;

    logic                 routing;
    logic [n_req-1:0]     req_valid;
    noc_pkg::flit_t       req_flit [n_req];
    logic [n_req-1:0]     slot_full;
    noc_pkg::flit_t       slot_flit [n_req];
    logic [1:0]           last_grant;
    logic [1:0]           grant_idx;
    logic                 grant_found;

    assign routing = (routing_state == noc_pkg::ROUTING);

    // Slot 0 is init, slot 1 is ack and slot 2 is local injection
    assign req_valid[0] = init_valid;
    assign req_valid[1] = ack_valid;
    assign req_valid[2] = inject_valid && routing;
    assign req_flit[0]  = init_flit;
    assign req_flit[1]  = ack_flit;
    assign req_flit[2]  = inject_flit;

    assign inject_busy = slot_full[2] || !routing;

    // Search starts just after the previous winner
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = last_grant;
        for (int k = 1; k <= n_req; k++) begin
            if (!grant_found && slot_full[(last_grant + k) % n_req]) begin
                grant_found = 1'b1;
                grant_idx   = 2'((last_grant + k) % n_req);
            end
        end
    end

    assign link_valid = grant_found;
    assign link_flit  = slot_flit[grant_idx];

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full  <= '0;
            last_grant <= 2'(n_req - 1);  // So slot 0 is first in line
        end else begin
            for (int i = 0; i < n_req; i++) begin
                if (req_valid[i] && !slot_full[i]) begin
                    slot_full[i] <= 1'b1;
                end else if (grant_found && (grant_idx == i)) begin
                    slot_full[i] <= 1'b0;
                end
            end
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge nocclk) begin
        for (int i = 0; i < n_req; i++) begin
            if (req_valid[i] && !slot_full[i]) begin
                slot_flit[i] <= req_flit[i];
            end
        end
    end

endmodule

// ==== verilog/ingress_handler.sv ====
`timescale 1ns/1ns
`include "noc_settings.svh"

module ingress_handler (
    input  logic                    nocclk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  noc_pkg::flit_t          in_flit,
    input  logic [`NOC_ID_W-1:0]    node_id,
    input  noc_pkg::routing_state_t routing_state,
    output logic                    ack_valid,
    output noc_pkg::flit_t          ack_flit,
    output logic                    deliver_valid,
    output noc_pkg::flit_t          deliver_flit
);
    logic           is_system;
    logic           is_request;
    logic           answer;
    logic           deliver_hit;
    noc_pkg::flit_t ack_d;

    assign is_system = in_valid && (in_flit.flit_type == noc_pkg::SYSTEM);

    // Requests normally arrive as broadcasts but a directed one is honored too
    assign is_request = is_system
                        && ((in_flit.sys_op == noc_pkg::S_PARENT_REQUEST)
                            || (in_flit.sys_op == noc_pkg::S_JOIN_REQUEST))
                        && ((in_flit.dst_id == `NOC_BROADCAST_ID)
                            || (in_flit.dst_id == node_id));

    assign answer = is_request && (routing_state == noc_pkg::ROUTING);

    assign deliver_hit = in_valid
                         && (in_flit.flit_type == noc_pkg::DATA)
                         && (in_flit.dst_id == node_id);

    always_comb begin
        ack_d.flit_type = noc_pkg::SYSTEM;
        ack_d.src_id    = node_id;
        ack_d.dst_id    = in_flit.src_id;  // Reply straight to the requester
        ack_d.payload   = '0;
        if (in_flit.sys_op == noc_pkg::S_JOIN_REQUEST) begin
            ack_d.sys_op = noc_pkg::S_JOIN_ACK;
        end else begin
            ack_d.sys_op = noc_pkg::S_PARENT_ACK;
        end
    end

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            ack_valid     <= 1'b0;
            deliver_valid <= 1'b0;
        end else begin
            ack_valid     <= answer;
            deliver_valid <= deliver_hit;
        end
    end

    always_ff @(posedge nocclk) begin
        if (answer) begin
            ack_flit <= ack_d;
        end
        if (deliver_hit) begin
            deliver_flit <= in_flit;
        end
    end

endmodule

// ==== verilog/routing_fsm.sv ====
`timescale 1ns/1ns

module routing_fsm (
    input  logic                    nocclk,
    input  logic                    rst_n,
    input  logic                    is_next_state,
    input  logic                    is_reset_state,
    output noc_pkg::routing_state_t routing_state
);
    noc_pkg::routing_state_t state_q;
    noc_pkg::routing_state_t state_d;
    noc_pkg::routing_state_t step_state;

    // Fixed walk through the initialization sequence
    always_comb begin
        unique case (state_q)
            noc_pkg::INIT: begin
                step_state = noc_pkg::I_GENERATE_PARENT_REQUEST;
            end
            noc_pkg::I_GENERATE_PARENT_REQUEST: begin
                step_state = noc_pkg::I_WAIT_PARENT_ACK;
            end
            noc_pkg::I_WAIT_PARENT_ACK: begin
                step_state = noc_pkg::I_GENERATE_JOIN_REQUEST;
            end
            noc_pkg::I_GENERATE_JOIN_REQUEST: begin
                step_state = noc_pkg::I_WAIT_JOIN_ACK;
            end
            noc_pkg::I_WAIT_JOIN_ACK: begin
                step_state = noc_pkg::ROUTING;
            end
            default: begin
                step_state = noc_pkg::ROUTING;  // ROUTING is terminal
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (is_reset_state) begin
            state_d = noc_pkg::INIT;  // A timeout beats any step request
        end else if (is_next_state) begin
            state_d = step_state;
        end
    end

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= noc_pkg::INIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign routing_state = state_q;

endmodule

// ==== verilog/auto_init.sv ====
`timescale 1ns/1ns
`include "noc_settings.svh"

module auto_init #(
    parameter int pack_time_out = `NOC_PACK_TIME_OUT,
    parameter int jack_time_out = `NOC_JACK_TIME_OUT
) (
    input  logic                    nocclk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  noc_pkg::flit_t          in_flit,
    input  noc_pkg::routing_state_t routing_state,
    input  logic [`NOC_ID_W-1:0]    node_id,
    output logic                    is_next_state,
    output logic                    is_reset_state,
    output logic                    init_valid,
    output noc_pkg::flit_t          init_flit
);
    localparam int max_time_out = (pack_time_out > jack_time_out) ? pack_time_out
                                                                   : jack_time_out;
    localparam int cnt_w = $clog2(max_time_out + 1);

    logic [cnt_w-1:0] time_out_cnt;
    logic             in_waiting;
    logic             ack_for_me;

    // A SYSTEM flit aimed at this node, still to be checked for the opcode
    assign ack_for_me = in_valid
                        && (in_flit.flit_type == noc_pkg::SYSTEM)
                        && (in_flit.dst_id == node_id);

    assign in_waiting = (routing_state == noc_pkg::I_WAIT_PARENT_ACK)
                        || (routing_state == noc_pkg::I_WAIT_JOIN_ACK);

    always_comb begin
        init_flit.flit_type = noc_pkg::SYSTEM;
        init_flit.sys_op    = noc_pkg::S_PARENT_REQUEST;
        init_flit.src_id    = node_id;
        init_flit.dst_id    = `NOC_BROADCAST_ID;  // Requests go to every neighbor
        init_flit.payload   = '0;
        init_valid          = 1'b0;
        is_next_state       = 1'b0;
        is_reset_state      = 1'b0;

        unique case (routing_state)
            noc_pkg::INIT: begin
                is_next_state = 1'b1;
            end
            noc_pkg::I_GENERATE_PARENT_REQUEST: begin
                init_valid       = 1'b1;
                init_flit.sys_op = noc_pkg::S_PARENT_REQUEST;
                is_next_state    = 1'b1;
            end
            noc_pkg::I_WAIT_PARENT_ACK: begin
                if (ack_for_me && (in_flit.sys_op == noc_pkg::S_PARENT_ACK)) begin
                    is_next_state = 1'b1;
                end else if (time_out_cnt == cnt_w'(pack_time_out)) begin
                    is_reset_state = 1'b1;
                end
            end
            noc_pkg::I_GENERATE_JOIN_REQUEST: begin
                init_valid       = 1'b1;
                init_flit.sys_op = noc_pkg::S_JOIN_REQUEST;
                is_next_state    = 1'b1;
            end
            noc_pkg::I_WAIT_JOIN_ACK: begin
                if (ack_for_me && (in_flit.sys_op == noc_pkg::S_JOIN_ACK)) begin
                    is_next_state = 1'b1;
                end else if (time_out_cnt == cnt_w'(jack_time_out)) begin
                    is_reset_state = 1'b1;
                end
            end
            default: begin
                // Once routing the init block stays silent
            end
        endcase
    end

    // Counts only while waiting so each wait starts from zero
    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            time_out_cnt <= '0;
        end else if (in_waiting) begin
            time_out_cnt <= time_out_cnt + 1'b1;
        end else begin
            time_out_cnt <= '0;
        end
    end

endmodule

// ==== verilog/noc_pkg.sv ====
`include "noc_settings.svh"

package noc_pkg;

    // SYSTEM flits steer initialization and DATA flits carry traffic
    typedef enum logic [0:0] {
        SYSTEM = 1'b0,
        DATA   = 1'b1
    } flit_type_t;

    typedef enum logic [1:0] {
        S_PARENT_REQUEST = 2'd0,
        S_PARENT_ACK     = 2'd1,
        S_JOIN_REQUEST   = 2'd2,
        S_JOIN_ACK       = 2'd3
    } sys_op_t;

    // The node walks these in order and parks in ROUTING
    typedef enum logic [2:0] {
        INIT                      = 3'd0,
        I_GENERATE_PARENT_REQUEST = 3'd1,
        I_WAIT_PARENT_ACK         = 3'd2,
        I_GENERATE_JOIN_REQUEST   = 3'd3,
        I_WAIT_JOIN_ACK           = 3'd4,
        ROUTING                   = 3'd5
    } routing_state_t;

    typedef struct packed {
        flit_type_t                flit_type;
        sys_op_t                   sys_op;    // Only meaningful for SYSTEM flits
        logic [`NOC_ID_W-1:0]      src_id;
        logic [`NOC_ID_W-1:0]      dst_id;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage

// ==== verilog/noc_settings.svh ====
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Width of a node ID carried in src_id and dst_id
`define NOC_ID_W 8

// Payload bits per flit
`define NOC_PAYLOAD_W 12

// Destination that every node accepts
`define NOC_BROADCAST_ID ({`NOC_ID_W{1'b1}})

// Cycles spent in I_WAIT_PARENT_ACK before giving up
`define NOC_PACK_TIME_OUT 100

// Cycles spent in I_WAIT_JOIN_ACK before giving up
`define NOC_JACK_TIME_OUT 300

`endif
